// ==== fp_add_unit.f ====
+incdir+include
src/fp_pkg.sv
src/fp_req_ctrl.sv
src/fp_unpack_align.sv
src/fp_add_norm.sv
src/grs_rounder.sv
src/fp_round_pack.sv
src/fp_add_unit.sv
test/tb_clock_gen.sv
test/fp_add_unit_tb.sv

// ==== include/fp_settings.svh ====
// Binary16 format sizes for the floating-point adder
// Field widths, exponent bias and the extra alignment precision

`ifndef FP_SETTINGS_SVH
`define FP_SETTINGS_SVH

// Packed word and field widths
`define FP_WIDTH     16
`define FP_EXP_W     5
`define FP_MANT_W    10
`define FP_EXP_BIAS  15

// Extra fraction bits kept below the mantissa while aligning
`define FP_PREC_BITS 14

// Hidden bit, stored fraction and precision bits
`define FP_ALIGN_W   (1 + `FP_MANT_W + `FP_PREC_BITS)

`endif

// ==== src/fp_add_norm.sv ====
// Stages 2 and 3 of the adder pipeline
// Adds or subtracts the aligned significands, then normalizes
// the sum with a leading-one priority encoder

`timescale 1ns/1ns
`default_nettype none

`include "fp_settings.svh"

module fp_add_norm import fp_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire fp_align_stage_t align,
    output fp_norm_stage_t       norm
);

    // Enough bits to index every bit of the sum
    localparam int LW = $clog2(`FP_ALIGN_W + 1);

    fp_sum_stage_t  s2_nxt;
    fp_sum_stage_t  s2;
    fp_norm_stage_t n_nxt;
    fp_sum_t        diff;
    logic [LW-1:0]  lead;
    logic [LW-1:0]  shl;

    // --------------------------------------------------
    // Stage 2 add or subtract
    // --------------------------------------------------
    always_comb begin
        s2_nxt             = '0;
        s2_nxt.valid       = align.valid;
        s2_nxt.exp         = align.exp;
        s2_nxt.neg_zero    = align.neg_zero;
        s2_nxt.special     = align.special;
        s2_nxt.special_val = align.special_val;
        s2_nxt.mode        = align.mode;

        diff = {1'b0, align.mant_big} - {1'b0, align.mant_small};
        if (!align.sub) begin
            s2_nxt.sum  = {1'b0, align.mant_big} + {1'b0, align.mant_small};
            s2_nxt.sign = align.sign;
        end else if (diff[`FP_ALIGN_W]) begin
            // Borrow, so the smaller side wins and the sign flips
            s2_nxt.sum  = {1'b0, align.mant_small} - {1'b0, align.mant_big};
            s2_nxt.sign = ~align.sign;
        end else begin
            s2_nxt.sum  = diff;
            s2_nxt.sign = align.sign;
        end
    end

    // --------------------------------------------------
    // Stage 3 normalize
    // --------------------------------------------------
    always_comb begin
        // Highest set bit wins
        lead = '0;
        for (int i = 0; i <= `FP_ALIGN_W; i++) begin
            if (s2.sum[i]) begin
                lead = LW'(i);
            end
        end

        n_nxt             = '0;
        n_nxt.valid       = s2.valid;
        n_nxt.sign        = s2.sign;
        n_nxt.is_zero     = (s2.sum == '0);
        n_nxt.neg_zero    = s2.neg_zero;
        n_nxt.special     = s2.special;
        n_nxt.special_val = s2.special_val;
        n_nxt.mode        = s2.mode;

        shl = '0;
        if (s2.sum[`FP_ALIGN_W]) begin
            // Carry out, one place right with the lost bit folded into sticky
            n_nxt.mant = {s2.sum[`FP_ALIGN_W:2], s2.sum[1] | s2.sum[0]};
            n_nxt.exp  = fp_sexp_t'({1'b0, s2.exp}) + fp_sexp_t'(1);
        end else begin
            // Leading one moves up to the hidden-bit position
            shl        = LW'(`FP_ALIGN_W - 1) - lead;
            n_nxt.mant = s2.sum[`FP_ALIGN_W-1:0] << shl;
            n_nxt.exp  = fp_sexp_t'({1'b0, s2.exp}) - fp_sexp_t'({1'b0, shl});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2   <= '0;
            norm <= '0;
        end else begin
            s2   <= s2_nxt;
            norm <= n_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/fp_add_unit.sv ====
// Top level of the binary16 adder
// Handshake controller feeding the four-stage add pipeline

`timescale 1ns/1ns
`default_nettype none

module fp_add_unit import fp_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire          req,
    input  wire fp_req_t request,
    output logic         ack,
    output fp_word_t     result
);

    fp_req_t         launch;
    logic            launch_valid;
    fp_align_stage_t align;
    fp_norm_stage_t  norm;
    fp_result_t      done;

    // Handshake side
    fp_req_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .request      (request),
        .ack          (ack),
        .launch       (launch),
        .launch_valid (launch_valid),
        .done         (done),
        .result       (result)
    );

    // Stage 1
    fp_unpack_align u_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .launch       (launch),
        .launch_valid (launch_valid),
        .stage        (align)
    );

    // Stages 2 and 3
    fp_add_norm u_add_norm (
        .clk   (clk),
        .rst_n (rst_n),
        .align (align),
        .norm  (norm)
    );

    // Stage 4
    fp_round_pack u_round_pack (
        .clk   (clk),
        .rst_n (rst_n),
        .norm  (norm),
        .done  (done)
    );

endmodule

`default_nettype wire

// ==== src/fp_pkg.sv ====
// Shared types of the floating-point adder
// Field typedefs, rounding-mode enum, request and stage payload structs

`default_nettype none

`include "fp_settings.svh"

package fp_pkg;

    // Field and working widths
    typedef logic        [`FP_WIDTH-1:0]   fp_word_t;
    typedef logic        [`FP_EXP_W-1:0]   fp_exp_t;
    typedef logic        [`FP_MANT_W-1:0]  fp_mant_t;
    typedef logic        [`FP_ALIGN_W-1:0] fp_align_t;
    // One extra bit for the carry of the add
    typedef logic        [`FP_ALIGN_W:0]   fp_sum_t;
    // Signed so normalization can push it below zero
    typedef logic signed [`FP_EXP_W:0]     fp_sexp_t;

    // Rounding mode, chosen per request
    typedef enum logic [1:0] {
        RNE = 2'd0,
        RTZ = 2'd1,
        RUP = 2'd2,
        RDN = 2'd3
    } round_mode_e;

    typedef struct packed {
        fp_word_t    a;
        fp_word_t    b;
        round_mode_e mode;
    } fp_req_t;

    // --------------------------------------------------
    // Pipeline stage payloads
    // --------------------------------------------------
    typedef struct packed {
        logic        valid;
        fp_exp_t     exp;
        logic        sign;
        logic        sub;
        logic        neg_zero;
        fp_align_t   mant_big;
        fp_align_t   mant_small;
        logic        special;
        fp_word_t    special_val;
        round_mode_e mode;
    } fp_align_stage_t;

    typedef struct packed {
        logic        valid;
        fp_exp_t     exp;
        logic        sign;
        fp_sum_t     sum;
        logic        neg_zero;
        logic        special;
        fp_word_t    special_val;
        round_mode_e mode;
    } fp_sum_stage_t;

    typedef struct packed {
        logic        valid;
        logic        sign;
        fp_align_t   mant;
        fp_sexp_t    exp;
        logic        is_zero;
        logic        neg_zero;
        logic        special;
        fp_word_t    special_val;
        round_mode_e mode;
    } fp_norm_stage_t;

    typedef struct packed {
        logic     valid;
        fp_word_t value;
    } fp_result_t;

endpackage

`default_nettype wire

// ==== src/fp_req_ctrl.sv ====
// Four-phase req/ack controller of the adder
// Launches one operation per handshake and holds its result

`timescale 1ns/1ns
`default_nettype none

module fp_req_ctrl import fp_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             req,
    input  wire fp_req_t    request,
    output logic            ack,
    output fp_req_t         launch,
    output logic            launch_valid,
    input  wire fp_result_t done,
    output fp_word_t        result
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } ctrl_state_e;

    ctrl_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            ack          <= 1'b0;
            launch       <= '0;
            launch_valid <= 1'b0;
            result       <= '0;
        end else begin
            // Launch is a single-cycle pulse
            launch_valid <= 1'b0;
            case (state)
                IDLE: begin
                    // Capture operands and mode on the sampled req
                    if (req) begin
                        launch       <= request;
                        launch_valid <= 1'b1;
                        state        <= BUSY;
                    end
                end
                BUSY: begin
                    // Result held here until the next handshake completes
                    if (done.valid) begin
                        result <= done.value;
                        ack    <= 1'b1;
                        state  <= DONE;
                    end
                end
                DONE: begin
                    // Requester has dropped req, close the handshake
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/fp_round_pack.sv ====
// Stage 4 of the adder pipeline
// Rounds, handles exponent overflow and underflow,
// resolves the sign of zero and packs the result word

`timescale 1ns/1ns
`default_nettype none

`include "fp_settings.svh"

module fp_round_pack import fp_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire fp_norm_stage_t norm,
    output fp_result_t          done
);

    // All-ones biased exponent, 31 for binary16
    localparam int EXP_MAX = 2 * `FP_EXP_BIAS + 1;

    logic [`FP_MANT_W:0]          rounded;
    logic                         carry;
    logic signed [`FP_EXP_W+1:0]  exp_r;
    fp_word_t                     word;

    grs_rounder u_rounder (
        .value     (norm.mant),
        .sign      (norm.sign),
        .mode      (norm.mode),
        .rounded   (rounded),
        .carry_out (carry)
    );

    always_comb begin
        // One extra bit so a carry out of 31 does not wrap
        exp_r = {norm.exp[`FP_EXP_W], norm.exp} + {{(`FP_EXP_W+1){1'b0}}, carry};

        if (norm.special) begin
            word = norm.special_val;
        end else if (norm.is_zero || (exp_r <= 0)) begin
            // Exact cancellation and flushed underflow share one zero
            word = {norm.neg_zero, {(`FP_WIDTH-1){1'b0}}};
        end else if (exp_r >= EXP_MAX) begin
            // Infinity of the result sign in every mode
            word = {norm.sign, {`FP_EXP_W{1'b1}}, {`FP_MANT_W{1'b0}}};
        end else begin
            word = {norm.sign, exp_r[`FP_EXP_W-1:0], rounded[`FP_MANT_W-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= '0;
        end else begin
            done.valid <= norm.valid;
            done.value <= word;
        end
    end

endmodule

`default_nettype wire

// ==== src/fp_unpack_align.sv ====
// Stage 1 of the adder pipeline
// Unpacks and classifies both operands, orders them by magnitude,
// aligns the smaller significand and flags special results

`timescale 1ns/1ns
`default_nettype none

`include "fp_settings.svh"

module fp_unpack_align import fp_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire fp_req_t      launch,
    input  wire               launch_valid,
    output fp_align_stage_t   stage
);

    // Quiet NaN, 7E00 for binary16
    localparam fp_word_t QNAN = {1'b0, {`FP_EXP_W{1'b1}}, 1'b1, {(`FP_MANT_W-1){1'b0}}};

    logic                sign_a;
    logic                sign_b;
    fp_exp_t             exp_a;
    fp_exp_t             exp_b;
    fp_mant_t            man_a;
    fp_mant_t            man_b;
    logic                zero_a;
    logic                zero_b;
    logic                inf_a;
    logic                inf_b;
    logic                nan_a;
    logic                nan_b;
    fp_exp_t             eff_a;
    fp_exp_t             eff_b;
    logic                a_ge_b;
    fp_exp_t             diff;
    logic [`FP_MANT_W:0] sig_big;
    logic [`FP_MANT_W:0] sig_small;
    fp_align_stage_t     nxt;

    assign {sign_a, exp_a, man_a} = launch.a;
    assign {sign_b, exp_b, man_b} = launch.b;

    // Operand classes
    assign zero_a = (exp_a == '0) && (man_a == '0);
    assign zero_b = (exp_b == '0) && (man_b == '0);
    assign inf_a  = (&exp_a) && (man_a == '0);
    assign inf_b  = (&exp_b) && (man_b == '0);
    assign nan_a  = (&exp_a) && (man_a != '0);
    assign nan_b  = (&exp_b) && (man_b != '0);

    // Denormals sit at the scale of exponent 1
    assign eff_a = (exp_a == '0) ? fp_exp_t'(1) : exp_a;
    assign eff_b = (exp_b == '0) ? fp_exp_t'(1) : exp_b;

    // Exponent first, then fraction
    assign a_ge_b = {exp_a, man_a} >= {exp_b, man_b};

    always_comb begin
        nxt          = '0;
        nxt.valid    = launch_valid;
        nxt.mode     = launch.mode;
        nxt.sub      = sign_a ^ sign_b;
        nxt.neg_zero = zero_a & zero_b & sign_a & sign_b;

        // Larger operand sets exponent and sign
        if (a_ge_b) begin
            nxt.exp   = eff_a;
            nxt.sign  = sign_a;
            sig_big   = {|exp_a, man_a};
            sig_small = {|exp_b, man_b};
            diff      = eff_a - eff_b;
        end else begin
            nxt.exp   = eff_b;
            nxt.sign  = sign_b;
            sig_big   = {|exp_b, man_b};
            sig_small = {|exp_a, man_a};
            diff      = eff_b - eff_a;
        end

        // Bits shifted past the precision field are dropped
        nxt.mant_big   = {sig_big, {`FP_PREC_BITS{1'b0}}};
        nxt.mant_small = fp_align_t'({sig_small, {`FP_PREC_BITS{1'b0}}}) >> diff;

        // Special results in priority order
        if (nan_a || nan_b || (inf_a && inf_b && nxt.sub)) begin
            nxt.special     = 1'b1;
            nxt.special_val = QNAN;
        end else if (inf_a || zero_b) begin
            nxt.special     = 1'b1;
            nxt.special_val = launch.a;
        end else if (inf_b || zero_a) begin
            nxt.special     = 1'b1;
            nxt.special_val = launch.b;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage <= '0;
        end else begin
            stage <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== src/grs_rounder.sv ====
// Guard/round/sticky rounder for the four rounding modes
// Keeps the hidden bit and mantissa, reports carry out of the increment

`timescale 1ns/1ns
`default_nettype none

`include "fp_settings.svh"

module grs_rounder import fp_pkg::*; (
    input  wire fp_align_t    value,
    input  wire               sign,
    input  wire round_mode_e  mode,
    output logic [`FP_MANT_W:0] rounded,
    output logic              carry_out
);

    logic [`FP_MANT_W:0] kept;
    logic                guard;
    logic                sticky;
    logic                inexact;
    logic                inc;

    // Hidden bit plus stored fraction
    assign kept    = value[`FP_ALIGN_W-1 -: `FP_MANT_W+1];
    assign guard   = value[`FP_PREC_BITS-1];
    assign sticky  = |value[`FP_PREC_BITS-2:0];
    assign inexact = guard | sticky;

    always_comb begin
        case (mode)
            // Ties go to the even significand
            RNE:     inc = guard & (sticky | kept[0]);
            RTZ:     inc = 1'b0;
            RUP:     inc = inexact & ~sign;
            RDN:     inc = inexact & sign;
            default: inc = 1'b0;
        endcase
    end

    // Wrap to zero on carry, which reads as 1.0 one exponent up
    assign {carry_out, rounded} = {1'b0, kept} + {{(`FP_MANT_W+1){1'b0}}, inc};

endmodule

`default_nettype wire

// ==== test/fp_add_unit_tb.sv ====
// Testbench of the binary16 adder
// Four-phase driver, reference adder, result checker and timeout

`timescale 1ns/1ns
`default_nettype none

module fp_add_unit_tb import fp_pkg::*; ();

    localparam int N_TRANS     = 257;
    localparam int CYCLE_LIMIT = 16 + 40 * N_TRANS;

    logic     clk;
    logic     rst_n;
    logic     req;
    fp_req_t  request;
    logic     ack;
    fp_word_t result;

    int       cycle = 0;
    int       checks = 0;
    int       errors = 0;
    int       grp_checks = 0;
    int       grp_errors = 0;
    int       hold_cycles = 2;
    integer   seed = 32'hfee04d13;
    fp_word_t expect_q[$];

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fp_add_unit dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .request (request),
        .ack     (ack),
        .result  (result)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // --------------------------------------------------
    // Reference model and checking
    // --------------------------------------------------
    function automatic fp_word_t ref_fp_add(input fp_word_t a, input fp_word_t b,
                                            input round_mode_e mode);
        int          ea;
        int          eb;
        int          eff_a;
        int          eff_b;
        int          exp;
        int          lead;
        int unsigned sig_a;
        int unsigned sig_b;
        int unsigned big_sig;
        int unsigned small_sig;
        int unsigned sum;
        int unsigned mant;
        int unsigned kept;
        logic        sign;
        logic        nz;
        logic        dropped;
        logic        inc;
        ea    = a[14:10];
        eb    = b[14:10];
        nz    = a[15] && b[15] && (a[14:0] == 0) && (b[14:0] == 0);
        // Special cases with NaN first
        if ((ea == 31 && a[9:0] != 0) || (eb == 31 && b[9:0] != 0))
            return 16'h7e00;
        if (ea == 31 && eb == 31 && a[15] != b[15])
            return 16'h7e00;
        if (ea == 31 || b[14:0] == 0)
            return a;
        if (eb == 31 || a[14:0] == 0)
            return b;
        // Denormals get no hidden bit and sit at exponent 1
        sig_a = (ea != 0) ? (1024 + a[9:0]) : a[9:0];
        sig_b = (eb != 0) ? (1024 + b[9:0]) : b[9:0];
        eff_a = (ea == 0) ? 1 : ea;
        eff_b = (eb == 0) ? 1 : eb;
        if (a[14:0] >= b[14:0]) begin
            sign      = a[15];
            exp       = eff_a;
            big_sig   = sig_a << 14;
            small_sig = (sig_b << 14) >> (eff_a - eff_b);
        end else begin
            sign      = b[15];
            exp       = eff_b;
            big_sig   = sig_b << 14;
            small_sig = (sig_a << 14) >> (eff_b - eff_a);
        end
        if (a[15] == b[15]) begin
            sum = big_sig + small_sig;
        end else if (small_sig > big_sig) begin
            sum  = small_sig - big_sig;
            sign = !sign;
        end else begin
            sum = big_sig - small_sig;
        end
        if (sum == 0)
            return {nz, 15'h0};
        // On carry the lost bit folds into sticky
        // Otherwise the leading one moves up to bit 24
        if (sum >= (1 << 25)) begin
            mant = (sum >> 1) | (sum & 1);
            exp  = exp + 1;
        end else begin
            lead = 24;
            while (((sum >> lead) & 1) == 0)
                lead--;
            mant = sum << (24 - lead);
            exp  = exp - (24 - lead);
        end
        kept    = mant >> 14;
        dropped = (mant & 32'h3fff) != 0;
        case (mode)
            RNE:     inc = ((mant >> 13) & 1) && (((mant & 32'h1fff) != 0) || (kept & 1));
            RUP:     inc = dropped && !sign;
            RDN:     inc = dropped && sign;
            default: inc = 1'b0;
        endcase
        kept = kept + inc;
        if (kept == 2048) begin
            kept = 1024;
            exp  = exp + 1;
        end
        if (exp <= 0)
            return {nz, 15'h0};
        if (exp >= 31)
            return {sign, 5'h1f, 10'h0};
        return {sign, exp[4:0], kept[9:0]};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Result check at every rise of ack
    initial begin
        forever begin
            @(posedge ack);
            #1;
            if (expect_q.size() == 0) begin
                errors++;
                $display("[ERROR] %0t ns ack rose with no operation pending", $time);
            end else begin
                check_val("result", result, expect_q.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // Handshake driver
    // --------------------------------------------------
    task automatic run_op(input fp_word_t a, input fp_word_t b, input round_mode_e mode);
        int       start;
        fp_word_t held;
        request.a    = a;
        request.b    = b;
        request.mode = mode;
        expect_q.push_back(ref_fp_add(a, b, mode));
        req   = 1'b1;
        start = cycle;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        // Edges after the one that sampled req
        check_val("ack latency", cycle - start - 1, 5);
        held = result;
        repeat (hold_cycles) begin
            @(posedge clk);
            #1;
            check_val("ack", ack, 1);
            check_val("result hold", result, held);
        end
        req = 1'b0;
        @(posedge clk);
        #1;
        check_val("ack", ack, 0);
        check_val("result hold", result, held);
        while (ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_all_modes(input fp_word_t a, input fp_word_t b);
        for (int m = 0; m < 4; m++)
            run_op(a, b, round_mode_e'(m));
    endtask

    task automatic report_test(input string name);
        $display("test %-12s %0d checks, %0d errors", name, checks - grp_checks,
                 errors - grp_errors);
        grp_checks = checks;
        grp_errors = errors;
    endtask

    // Run limit from the transaction count
    initial begin
        wait (cycle >= CYCLE_LIMIT);
        $display("Timeout after %0d cycles, the DUT stopped answering", cycle);
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rm;
        req     = 1'b0;
        request = '0;
        @(posedge rst_n);
        @(posedge clk);
        #1;

        check_val("ack", ack, 0);
        check_val("result", result, 0);
        run_op(16'h3c00, 16'h3c00, RNE);
        // Slow requester keeps req high longer
        hold_cycles = 5;
        run_op(16'h4200, 16'hc000, RNE);
        hold_cycles = 2;
        report_test("handshake");

        run_op(16'h7e00, 16'h3c00, RNE);
        run_op(16'h3c00, 16'h7c01, RNE);
        run_op(16'h7c00, 16'hfc00, RNE);
        run_op(16'h7c00, 16'h3c00, RNE);
        run_op(16'hc000, 16'hfc00, RNE);
        run_op(16'h7c00, 16'h7c00, RNE);
        run_op(16'h0000, 16'h4500, RNE);
        run_op(16'h4500, 16'h8000, RNE);
        run_op(16'h8000, 16'h8000, RNE);
        run_op(16'h0000, 16'h8000, RNE);
        report_test("special");

        // Carries and lost small operands followed by near and exact cancellation
        run_op(16'h3e00, 16'h3e00, RNE);
        run_op(16'h4248, 16'h4248, RNE);
        run_op(16'h6400, 16'h1000, RNE);
        run_op(16'h7000, 16'h0001, RNE);
        run_op(16'h3c01, 16'hbc00, RNE);
        run_op(16'h3c00, 16'hbbff, RNE);
        run_op(16'h5555, 16'hd554, RNE);
        run_op(16'h4500, 16'hc500, RNE);
        report_test("normal");

        // Ties and inexact sums above and below a tie for both signs
        run_all_modes(16'h3c01, 16'h1000);
        run_all_modes(16'h3c00, 16'h1000);
        run_all_modes(16'h4000, 16'h8c01);
        run_all_modes(16'hbc01, 16'h9000);
        run_all_modes(16'hbc00, 16'h0c01);
        report_test("rounding");

        run_all_modes(16'h7bff, 16'h7bff);
        run_all_modes(16'hfbff, 16'hfbff);
        run_all_modes(16'h7bff, 16'h4c00);
        run_op(16'h0001, 16'h0001, RNE);
        run_op(16'h03ff, 16'h0001, RNE);
        run_op(16'h0400, 16'h8001, RNE);
        run_op(16'h0200, 16'h3c00, RNE);
        run_op(16'h8400, 16'h0200, RNE);
        report_test("range");

        for (int i = 0; i < 200; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            rm = $random(seed);
            run_op(ra[15:0], rb[15:0], round_mode_e'(rm[1:0]));
        end
        report_test("random");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Testbench clock and reset source
// 8 ns clock, active-low reset held for 16 cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release just after an edge so the DUT sees a clean deassert
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
